/* design/ext_reg_pkg.sv */
//****************************************
// Widths, constants and types shared by
// the SPI-filled external register bank
//****************************************
package ext_reg_pkg;

    // Register array geometry
    localparam int ADDR_W   = 5;                // Register index width
    localparam int DATA_W   = 32;               // Register width
    localparam int NUM_REGS = 1 << ADDR_W;      // 32 registers

    // SPI frame layout, address first then data, MSB first
    localparam int FRAME_BITS = ADDR_W + DATA_W;      // 37 bits
    localparam int CNT_W      = $clog2(FRAME_BITS + 2); // Room for one bit past a full frame

    // APB side
    localparam int APB_ADDR_W = 8;
    localparam int IDX_LSB    = 2;              // Word addressed, paddr[6:2] is the index

    typedef logic [ADDR_W-1:0]     reg_addr_t;  // Register index
    typedef logic [DATA_W-1:0]     reg_data_t;  // Register contents
    typedef logic [FRAME_BITS-1:0] frame_t;     // Raw shifted frame
    typedef logic [CNT_W-1:0]      bit_cnt_t;   // Received bit count
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;  // APB byte address

    // Done register
    // A write here locks the bank, a read releases it
    localparam reg_addr_t DONE_ADDR = reg_addr_t'(NUM_REGS - 1);

    // Bank state
    typedef enum logic {
        FILL_REGS = 1'b0,   // Accepting frames from the host
        WAIT_READ = 1'b1    // Locked until the done register is read
    } bank_state_t;

endpackage

/* design/spi_frame_receiver.sv */
//****************************************
// SPI mode 0 frame receiver with pin
// synchronizers and frame length check
//****************************************
`timescale 1ns/1ps

module spi_frame_receiver (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   spi_sclk,     // Host SPI clock, idle low
    input  logic                   spi_mosi,     // Sampled on sclk rising edge
    input  logic                   spi_cs_n,     // Frame select, active low
    output logic                   frame_valid,  // One pulse per good frame
    output ext_reg_pkg::reg_addr_t frame_addr,
    output ext_reg_pkg::reg_data_t frame_data
);
    import ext_reg_pkg::*;

    // Two-flop synchronizers, bit 1 is the safe output
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_sync;

    // Previous synchronized values for edge detection
    logic sclk_prev;
    logic cs_prev;

    logic     cs_active;   // Chip select asserted in clk domain
    logic     sclk_rise;   // Sample strobe
    logic     cs_rise;     // End of frame
    logic     frame_ok;    // End of frame with exactly FRAME_BITS bits
    frame_t   shift_q;     // Incoming bits, MSB first
    bit_cnt_t bit_cnt;     // Bits seen in the current frame

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sclk_sync <= '0;
            mosi_sync <= '0;
            cs_sync   <= '1;      // Start deselected
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_prev <= sclk_sync[1];
            cs_prev   <= cs_sync[1];
        end
    end

    assign cs_active = !cs_sync[1];

    // MOSI goes through the same depth as sclk so the two stay aligned
    assign sclk_rise = sclk_sync[1] && !sclk_prev && cs_active;
    assign cs_rise   = cs_sync[1] && !cs_prev;

    // Short and long frames fall through here and are dropped
    assign frame_ok = cs_rise && (bit_cnt == bit_cnt_t'(FRAME_BITS));

    // Shift register
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], mosi_sync[1]};
        end
    end

    // Bit counter, cleared while deselected
    // Saturates one past a full frame so long frames never wrap back to 37
    always_ff @(posedge clk) begin
        if (!nrst) begin
            bit_cnt <= '0;
        end else if (!cs_active) begin
            bit_cnt <= '0;
        end else if (sclk_rise && (bit_cnt != bit_cnt_t'(FRAME_BITS + 1))) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Frame strobe
    // Lands three clk cycles after cs_n rises at the pin
    always_ff @(posedge clk) begin
        if (!nrst) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= frame_ok;
        end
    end

    // Address in the top bits, data below
    always_ff @(posedge clk) begin
        if (frame_ok) begin
            frame_addr <= shift_q[FRAME_BITS-1 -: ADDR_W];
            frame_data <= shift_q[DATA_W-1:0];
        end
    end

endmodule

/* design/ext_reg_bank.sv */
//****************************************
// 32 x 32 register bank with fill/lock
// FSM and a registered read port
//****************************************
`timescale 1ns/1ps

module ext_reg_bank (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   frame_valid,  // Write strobe from SPI side
    input  ext_reg_pkg::reg_addr_t frame_addr,
    input  ext_reg_pkg::reg_data_t frame_data,
    input  logic                   rd_en,        // Read request from APB side
    input  ext_reg_pkg::reg_addr_t rd_addr,
    output ext_reg_pkg::reg_data_t rd_data,      // Valid with rd_ack
    output logic                   rd_ack,
    output logic                   data_ready    // High while locked
);
    import ext_reg_pkg::*;

    bank_state_t state;
    bank_state_t state_n;

    reg_data_t regs [NUM_REGS];

    logic wr_en;        // Frame accepted this cycle
    logic lock_req;     // Done register written
    logic release_req;  // Done register read while locked

    // Frames only land while filling, locked frames are lost
    assign wr_en       = frame_valid && (state == FILL_REGS);
    assign lock_req    = wr_en && (frame_addr == DONE_ADDR);
    assign release_req = rd_en && (rd_addr == DONE_ADDR) && (state == WAIT_READ);

    // Next state
    always_comb begin
        state_n = state;
        case (state)
            FILL_REGS: begin
                if (lock_req) begin
                    state_n = WAIT_READ;
                end
            end
            WAIT_READ: begin
                if (release_req) begin  // Same edge as the rd_ack
                    state_n = FILL_REGS;
                end
            end
            default: state_n = FILL_REGS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= FILL_REGS;
        end else begin
            state <= state_n;
        end
    end

    // Register array, cleared so the host sees zeros before the first fill
    always_ff @(posedge clk) begin
        if (!nrst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[frame_addr] <= frame_data;
        end
    end

    // Read port
    // Served in either state, a read colliding with a write sees the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= regs[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_en;    // One cycle later
        end
    end

    // Lock status straight from the state register
    assign data_ready = (state == WAIT_READ);

endmodule

/* design/apb_reg_port.sv */
//****************************************
// Read-only APB slave in front of the
// register bank read port
//****************************************
`timescale 1ns/1ps

module apb_reg_port (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  ext_reg_pkg::apb_addr_t paddr,     // Byte address
    output ext_reg_pkg::reg_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   rd_en,     // One pulse per APB read
    output ext_reg_pkg::reg_addr_t rd_addr,
    input  ext_reg_pkg::reg_data_t rd_data,   // Registered in the bank
    input  logic                   rd_ack
);
    import ext_reg_pkg::*;

    logic access;      // Access phase of any transfer
    logic rd_access;   // Access phase of a read
    logic wr_access;   // Access phase of a write
    logic rd_pending;  // Request already sent, waiting on rd_ack

    assign access    = psel && penable;
    assign rd_access = access && !pwrite;
    assign wr_access = access && pwrite;

    // Register index sits above the byte offset
    assign rd_addr = paddr[IDX_LSB +: ADDR_W];

    // First access cycle only
    // Pending flag blocks a second request while the bank answers
    assign rd_en = rd_access && !rd_pending;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_pending <= 1'b0;
        end else if (rd_en) begin
            rd_pending <= 1'b1;
        end else if (rd_ack) begin
            rd_pending <= 1'b0;     // Transfer completes this cycle
        end
    end

    // Completion
    // Reads finish in the second access cycle, writes in the first
    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        if (wr_access) begin
            pready  = 1'b1;
            pslverr = 1'b1;         // Bank is read-only from APB
        end else if (rd_pending && rd_ack) begin
            pready  = 1'b1;
        end
    end

    // Bank output is already a flop, pass it through while acknowledged
    assign prdata = rd_ack ? rd_data : '0;

endmodule

/* design/ext_reg_top.sv */
//****************************************
// External register subsystem top
//****************************************
`timescale 1ns/1ps

module ext_reg_top (
    input  logic                   clk,
    input  logic                   nrst,

    // SPI from host, mode 0
    input  logic                   spi_sclk,
    input  logic                   spi_mosi,
    input  logic                   spi_cs_n,

    // APB from the memory handler
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  ext_reg_pkg::apb_addr_t paddr,
    output ext_reg_pkg::reg_data_t prdata,
    output logic                   pready,
    output logic                   pslverr,

    output logic                   data_ready  // Bank filled and locked
);
    import ext_reg_pkg::*;

    // Receiver to bank
    logic      frame_valid;
    reg_addr_t frame_addr;
    reg_data_t frame_data;

    // APB port to bank
    logic      rd_en;
    reg_addr_t rd_addr;
    reg_data_t rd_data;
    logic      rd_ack;

    spi_frame_receiver rx_i (
        .clk         (clk),
        .nrst        (nrst),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n),
        .frame_valid (frame_valid),
        .frame_addr  (frame_addr),
        .frame_data  (frame_data)
    );

    ext_reg_bank bank_i (
        .clk         (clk),
        .nrst        (nrst),
        .frame_valid (frame_valid),
        .frame_addr  (frame_addr),
        .frame_data  (frame_data),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_ack      (rd_ack),
        .data_ready  (data_ready)
    );

    apb_reg_port apb_i (
        .clk     (clk),
        .nrst    (nrst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_ack  (rd_ack)
    );

endmodule

/* tests/ext_reg_tb_tasks.svh */
//****************************************
// SPI frame driver, APB read/write and
// data_ready wait tasks for the testbench
//****************************************
`ifndef EXT_REG_TB_TASKS_SVH
`define EXT_REG_TB_TASKS_SVH

// Advance n clocks, landing just after the edge where inputs change
task automatic step_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #2;
    end
endtask

// Mode 0 frame, MSB first
// nbits below or above FRAME_BITS makes a short or long frame
task automatic spi_send(input reg_addr_t addr, input reg_data_t data, input int nbits);
    logic [FRAME_BITS:0] word;   // One spare bit for long frames
    word = {addr, data, 1'b0};
    spi_cs_n = 1'b0;
    step_cycles(SCLK_HALF);
    for (int i = 0; i < nbits; i++) begin
        spi_mosi = word[FRAME_BITS - i];   // Set while sclk is low
        step_cycles(SCLK_HALF);
        spi_sclk = 1'b1;                   // Sampled here
        step_cycles(SCLK_HALF);
        spi_sclk = 1'b0;
    end
    step_cycles(SCLK_HALF);
    spi_cs_n = 1'b1;
    spi_mosi = 1'b0;
    step_cycles(FRAME_SETTLE);   // Frame lands a few clocks after cs_n rises
endtask

// Setup then access, sampled 1 ns after the inputs move
task automatic apb_transfer(input reg_addr_t addr, input logic write,
                            output reg_data_t rdata, output logic slverr, output logic ok);
    int cnt;
    cnt     = 0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = {1'b0, addr, 2'b00};     // Word address
    step_cycles(1);
    penable = 1'b1;
    #1;
    while (!pready && cnt < APB_TIMEOUT) begin
        @(posedge clk);
        #3;
        cnt++;
    end
    ok     = pready;
    rdata  = prdata;
    slverr = pslverr;
    step_cycles(1);              // Transfer completes on this edge
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

// Poll data_ready once per clock
task automatic wait_ready(input logic level, output logic ok);
    int cnt;
    cnt = 0;
    while (data_ready !== level && cnt < READY_TIMEOUT) begin
        step_cycles(1);
        cnt++;
    end
    ok = (data_ready === level);
endtask

`endif

/* tests/ext_reg_tb.sv */
//****************************************
// Testbench for the SPI-filled register
// bank with model, stimulus table, checks
//****************************************
`timescale 1ns/1ps

module ext_reg_tb;
    import ext_reg_pkg::*;

    localparam int MAX_TESTS     = 128;
    localparam int SCLK_HALF     = 4;    // clk cycles per sclk half period
    localparam int FRAME_SETTLE  = 8;    // Idle clocks after a frame
    localparam int APB_TIMEOUT   = 16;
    localparam int READY_TIMEOUT = 64;

    typedef enum {OP_FRAME, OP_BAD, OP_READ, OP_WRITE, OP_READY} op_t;

    logic      clk;
    logic      nrst;
    logic      spi_sclk;
    logic      spi_mosi;
    logic      spi_cs_n;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    reg_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      data_ready;

    // Stimulus table
    op_t       tbl_op   [MAX_TESTS];
    reg_addr_t tbl_addr [MAX_TESTS];
    reg_data_t tbl_data [MAX_TESTS];
    int        tbl_bits [MAX_TESTS];   // SPI bit count
    reg_data_t tbl_exp  [MAX_TESTS];   // Read data or data_ready level
    int        num_tests = 0;

    // Bank model
    reg_data_t ref_regs [NUM_REGS];
    logic      ref_locked;

    int seed     = 13;
    int err_cnt  = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    `include "ext_reg_tb_tasks.svh"

    ext_reg_top dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_cs_n   (spi_cs_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .data_ready (data_ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;   // 20 ns period

    function automatic void add_entry(op_t op, reg_addr_t addr, reg_data_t data,
                                      int bits, reg_data_t exp);
        tbl_op[num_tests]   = op;
        tbl_addr[num_tests] = addr;
        tbl_data[num_tests] = data;
        tbl_bits[num_tests] = bits;
        tbl_exp[num_tests]  = exp;
        num_tests++;
    endfunction

    // Frames only land while unlocked, the done register locks
    function automatic void add_frame(reg_addr_t addr);
        reg_data_t data;
        data = $random(seed);
        if (!ref_locked) begin
            ref_regs[addr] = data;
            ref_locked     = (addr == DONE_ADDR);
        end
        add_entry(OP_FRAME, addr, data, FRAME_BITS, '0);
    endfunction

    function automatic void add_bad(reg_addr_t addr, int bits);
        add_entry(OP_BAD, addr, $random(seed), bits, '0);   // Model unchanged
    endfunction

    function automatic void add_read(reg_addr_t addr);
        add_entry(OP_READ, addr, '0, 0, ref_regs[addr]);
        if (addr == DONE_ADDR) begin
            ref_locked = 1'b0;   // Reading the done register releases
        end
    endfunction

    function automatic void add_write(reg_addr_t addr);
        add_entry(OP_WRITE, addr, '0, 0, '0);
    endfunction

    function automatic void add_ready();
        add_entry(OP_READY, '0, '0, 0, reg_data_t'(ref_locked));
    endfunction

    function automatic void build_table();
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        ref_locked = 1'b0;
        add_ready();                              // Idle after reset
        add_read(0);
        add_read(7);
        add_read(DONE_ADDR);                      // No effect while filling
        for (int a = 0; a < NUM_REGS - 1; a++) begin
            add_frame(reg_addr_t'(a));
        end
        add_frame(DONE_ADDR);                     // Locks
        add_ready();
        for (int a = 0; a < NUM_REGS - 1; a++) begin
            add_read(reg_addr_t'(a));
        end
        add_frame(3);                             // Dropped while locked
        add_frame(17);
        add_frame(DONE_ADDR);
        add_ready();
        add_read(3);
        add_read(17);
        add_read(DONE_ADDR);                      // Release
        add_ready();
        add_frame(3);
        add_frame(17);
        add_read(3);
        add_read(17);
        add_bad(8, FRAME_BITS - 1);
        add_bad(9, FRAME_BITS + 1);
        add_bad(DONE_ADDR, FRAME_BITS - 1);
        add_ready();
        add_read(8);
        add_read(9);
        add_write(10);                            // Rejected
        add_read(10);
        add_frame(DONE_ADDR);                     // Lock again
        add_ready();
        add_write(DONE_ADDR);                     // Must not release
        add_ready();
        add_read(DONE_ADDR);
        add_ready();
    endfunction

    initial begin
        reg_data_t rdata;
        logic      slverr;
        logic      ok;
        int        errs_before;
        nrst     = 1'b0;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        spi_cs_n = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        build_table();
        step_cycles(2);
        nrst = 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            errs_before = err_cnt;
            case (tbl_op[t])
                OP_FRAME, OP_BAD: spi_send(tbl_addr[t], tbl_data[t], tbl_bits[t]);
                OP_READ, OP_WRITE: begin
                    apb_transfer(tbl_addr[t], tbl_op[t] == OP_WRITE, rdata, slverr, ok);
                    assert (ok) else begin
                        $display("APB transfer to register %0d got no pready in %0d cycles",
                                 tbl_addr[t], APB_TIMEOUT);
                        err_cnt++;
                    end
                    if (ok && tbl_op[t] == OP_READ) begin
                        assert (rdata == tbl_exp[t]) else begin
                            $display("error at %0t: reg %0d read 0x%08h, expected 0x%08h",
                                     $time, tbl_addr[t], rdata, tbl_exp[t]);
                            err_cnt++;
                        end
                    end
                    if (ok) begin
                        assert (slverr == (tbl_op[t] == OP_WRITE)) else begin
                            $display("error at %0t: reg %0d pslverr %0b on %s",
                                     $time, tbl_addr[t], slverr, tbl_op[t].name());
                            err_cnt++;
                        end
                    end
                end
                OP_READY: begin
                    wait_ready(tbl_exp[t][0], ok);
                    assert (ok) else begin
                        $display("data_ready did not settle at %0b within %0d cycles",
                                 tbl_exp[t][0], READY_TIMEOUT);
                        err_cnt++;
                    end
                end
                default: ;
            endcase
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("test %0d %s reg %0d: ok", t, tbl_op[t].name(), tbl_addr[t]);
            end else begin
                fail_cnt++;
                $display("test %0d %s reg %0d: failed", t, tbl_op[t].name(), tbl_addr[t]);
            end
        end
        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+tests
design/ext_reg_pkg.sv
design/spi_frame_receiver.sv
design/ext_reg_bank.sv
design/apb_reg_port.sv
design/ext_reg_top.sv
tests/ext_reg_tb.sv

/* Bender.yml */
package:
  name: ext_reg

sources:
  # Design, in compile order
  - files:
      - design/ext_reg_pkg.sv
      - design/spi_frame_receiver.sv
      - design/ext_reg_bank.sv
      - design/apb_reg_port.sv
      - design/ext_reg_top.sv

  # Testbench
  - target: test
    include_dirs:
      - tests
    files:
      - tests/ext_reg_tb.sv
